//--- flist.f
+incdir+logic
+incdir+test
logic/minn_pkg.sv
logic/minn_antenna_path.sv
logic/minn_metric.sv
logic/minn_peak_gate.sv
logic/minn_delay_line.sv
logic/minn_preamble_detector.sv
test/tb_minn_preamble_detector.sv

//--- Bender.yml
package:
  name: minn_preamble_detector

sources:
  - include_dirs:
      - logic
    files:
      - logic/minn_pkg.sv
      - logic/minn_antenna_path.sv
      - logic/minn_metric.sv
      - logic/minn_peak_gate.sv
      - logic/minn_delay_line.sv
      - logic/minn_preamble_detector.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/tb_minn_preamble_detector.sv

//--- test/tb_minn_model.svh
// ------------------------------------------------
// Software model and stimulus builders, included inside the testbench
// module. Works on its stim and exp_starts queues
// ------------------------------------------------
`ifndef TB_MINN_MODEL_SVH
`define TB_MINN_MODEL_SVH

// Component with a magnitude in [lo, lo+span) and the given sign
function automatic iq_comp_t random_comp(input int lo, input int span, input bit neg);
    int mag;
    mag = lo + int'($urandom % span);
    return neg ? iq_comp_t'(-mag) : iq_comp_t'(mag);
endfunction

function automatic void pad_zeros(input int n);
    for (int k = 0; k < n; k++) begin
        stim.push_back('0);
    end
endfunction

// Each component takes the sign opposite to the one a quarter earlier,
// so every lag product is negative and no frame start can be found
function automatic void fill_random(input int n);
    dual_sample_t s;
    dual_sample_t old;
    for (int k = 0; k < n; k++) begin
        old = '0;
        if (stim.size() >= `MINN_QUARTER) begin
            old = stim[stim.size() - `MINN_QUARTER];
        end
        s.ch0.i = random_comp(1, 2047, !old.ch0.i[`MINN_IN_W-1]);
        s.ch0.q = random_comp(1, 2047, !old.ch0.q[`MINN_IN_W-1]);
        s.ch1.i = random_comp(1, 2047, !old.ch1.i[`MINN_IN_W-1]);
        s.ch1.q = random_comp(1, 2047, !old.ch1.q[`MINN_IN_W-1]);
        stim.push_back(s);
    end
endfunction

// Quarters A, A, -A, -A with an independent nonzero A per antenna
function automatic void insert_preamble(output int start);
    iq_sample_t   a0 [`MINN_QUARTER];
    iq_sample_t   a1 [`MINN_QUARTER];
    dual_sample_t s;
    start = stim.size();
    for (int k = 0; k < `MINN_QUARTER; k++) begin
        a0[k].i = random_comp(256, 1024, 1'($urandom));
        a0[k].q = random_comp(256, 1024, 1'($urandom));
        a1[k].i = random_comp(256, 1024, 1'($urandom));
        a1[k].q = random_comp(256, 1024, 1'($urandom));
    end
    for (int qtr = 0; qtr < 4; qtr++) begin
        for (int k = 0; k < `MINN_QUARTER; k++) begin
            s.ch0 = a0[k];
            s.ch1 = a1[k];
            if (qtr >= 2) begin
                s.ch0.i = -a0[k].i;
                s.ch0.q = -a0[k].q;
                s.ch1.i = -a1[k].i;
                s.ch1.q = -a1[k].q;
            end
            stim.push_back(s);
        end
    end
endfunction

// Main peak sits on the last preamble sample and is recorded one index later
function automatic int main_tag(input int start);
    return start + `MINN_NFFT + `MINN_TIMING_OFFSET;
endfunction

function automatic longint lag_term(input iq_sample_t cur, input iq_sample_t old);
    return longint'($signed(cur.i)) * longint'($signed(old.i))
        + longint'($signed(cur.q)) * longint'($signed(old.q));
endfunction

// Sum over the quarter ending at last, samples before zero count as zero
function automatic longint window_sum(input longint terms [], input int last);
    longint acc;
    acc = 0;
    for (int m = last - `MINN_QUARTER + 1; m <= last; m++) begin
        if (m >= 0) begin
            acc += terms[m];
        end
    end
    return acc;
endfunction

function automatic void predict_starts();
    longint       c_tot [];
    longint       p_tot [];
    dual_sample_t old;
    longint       corr;
    longint       energy;
    longint       peak_val;
    int           peak_idx;
    int           low_cnt;
    int           n_total;
    bit           open;
    bit           above;
    n_total = stim.size();
    c_tot = new[n_total];
    p_tot = new[n_total];
    exp_starts.delete();
    for (int n = 0; n < n_total; n++) begin
        old = (n >= `MINN_QUARTER) ? stim[n - `MINN_QUARTER] : dual_sample_t'('0);
        c_tot[n] = lag_term(stim[n].ch0, old.ch0) + lag_term(stim[n].ch1, old.ch1);
        p_tot[n] = lag_term(stim[n].ch0, stim[n].ch0) + lag_term(stim[n].ch1, stim[n].ch1);
    end

    // Windows ending at n are judged when sample n+1 is accepted
    open = 1'b0;
    low_cnt = 0;
    peak_val = 0;
    peak_idx = 0;
    for (int n = 4 * `MINN_QUARTER - 1; n < n_total - 1; n++) begin
        corr = window_sum(c_tot, n) + window_sum(c_tot, n - 2 * `MINN_QUARTER);
        energy = window_sum(p_tot, n) + window_sum(p_tot, n - `MINN_QUARTER)
            + window_sum(p_tot, n - 2 * `MINN_QUARTER);
        if (corr < 0) begin
            corr = 0;
        end
        above = (corr << `MINN_THRESH_FRAC) > (energy * `MINN_THRESH);
        if (!open) begin
            low_cnt = 0;
            if (above) begin
                open = 1'b1;
                peak_val = corr;
                peak_idx = n + 1;
            end
        end else if (!above && (low_cnt == `MINN_HYST - 1)) begin
            open = 1'b0;
            low_cnt = 0;
            if (peak_idx + `MINN_TIMING_OFFSET <= n_total - 1 - `MINN_NFFT) begin
                exp_starts.push_back(peak_idx + `MINN_TIMING_OFFSET);
            end
        end else begin
            if (corr >= peak_val) begin
                peak_val = corr;
                peak_idx = n + 1;
            end
            low_cnt = above ? 0 : low_cnt + 1;
        end
    end
endfunction

`endif

//--- test/tb_minn_preamble_detector.sv
// ------------------------------------------------
// Directed tests of the preamble detector. Each test starts from reset,
// so sample indices count from zero within a test
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module tb_minn_preamble_detector;
    import minn_pkg::*;

    logic         clk;
    logic         rst;
    dual_sample_t in_sample;
    logic         in_valid;
    logic         in_ready;
    dual_sample_t out_sample;
    logic         out_valid;
    logic         out_ready;
    logic         frame_start;

    dual_sample_t stim [$];
    int           exp_starts [$];
    int           got_starts [$];
    int           error_count;
    int           check_count;
    int           test_count;
    int           single_start;
    bit           timed_out;

    minn_preamble_detector u_minn_preamble_detector (
        .clk         (clk),
        .rst         (rst),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_sample  (out_sample),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .frame_start (frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    `include "tb_minn_model.svh"

    function automatic void compare_value(input string name, input logic [63:0] got,
                                          input logic [63:0] exp);
        check_count++;
        assert (got === exp)
            else begin
                $display("Fail %s got %h expected %h", name, got, exp);
                error_count++;
            end
    endfunction

    function automatic void require(input bit ok, input string what);
        check_count++;
        assert (ok)
            else begin
                $display("%s", what);
                error_count++;
            end
    endfunction

    function automatic int tag_count(input int idx);
        int hits;
        hits = 0;
        foreach (got_starts[k]) begin
            if (got_starts[k] == idx) begin
                hits++;
            end
        end
        return hits;
    endfunction

    function automatic void match_tags();
        compare_value("frame_start tag count", got_starts.size(), exp_starts.size());
        for (int k = 0; (k < got_starts.size()) && (k < exp_starts.size()); k++) begin
            compare_value("frame_start index", got_starts[k], exp_starts[k]);
        end
    endfunction

    function automatic void print_test_line(input string name, input int in_cnt,
                                            input int out_cnt, input int errs0);
        test_count++;
        $display("test %-12s in %0d out %0d tags %0d errors %0d", name, in_cnt, out_cnt,
            got_starts.size(), error_count - errs0);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // ------------------------------------------------
    // Stream driver and monitor
    // ------------------------------------------------
    task automatic stream_stimulus(input bit stall, output int in_cnt, output int out_cnt);
        int next_idx;
        int cycles;
        int limit;
        int n_total;
        bit take_in;
        bit take_out;
        n_total  = stim.size();
        limit    = 8 * n_total + 100;
        in_cnt   = 0;
        out_cnt  = 0;
        next_idx = 0;
        cycles   = 0;
        got_starts.delete();
        apply_reset();
        in_sample <= stim[0];
        in_valid  <= 1'b1;
        out_ready <= 1'b1;
        while ((out_cnt < n_total - `MINN_NFFT) && (cycles < limit)) begin
            // Handshakes of the coming edge, seen while all inputs are stable
            @(negedge clk);
            take_in  = in_valid && in_ready;
            take_out = out_valid && out_ready;
            if (out_valid && !out_ready) begin
                require(!in_ready, "in_ready was high while the output was stalled");
            end
            if (out_valid) begin
                require(in_cnt > `MINN_NFFT, "out_valid rose before NFFT samples were accepted");
            end
            require(!frame_start || take_out, "frame_start was high without an output transfer");
            if (take_out) begin
                compare_value("out_sample", out_sample, stim[out_cnt]);
                if (frame_start) begin
                    got_starts.push_back(out_cnt);
                end
                out_cnt++;
            end
            if (take_in) begin
                in_cnt++;
            end

            @(posedge clk);
            if (take_in) begin
                next_idx++;
            end
            in_valid <= (next_idx < n_total);
            if (next_idx < n_total) begin
                in_sample <= stim[next_idx];
            end
            out_ready <= stall ? (($urandom % 3) != 0) : 1'b1;
            cycles++;
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        if (out_cnt < n_total - `MINN_NFFT) begin
            timed_out = 1'b1;
            $display("Timeout while waiting for output samples");
        end
        compare_value("accepted input count", in_cnt, n_total);
        compare_value("output count", out_cnt, n_total - `MINN_NFFT);
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic delay_passthrough();
        int in_cnt;
        int out_cnt;
        int errs0;
        errs0 = error_count;
        stim.delete();
        fill_random(3 * `MINN_NFFT);
        predict_starts();
        stream_stimulus(1'b0, in_cnt, out_cnt);
        match_tags();
        print_test_line("passthrough", in_cnt, out_cnt, errs0);
    endtask

    task automatic silent_input();
        int in_cnt;
        int out_cnt;
        int errs0;
        errs0 = error_count;
        stim.delete();
        pad_zeros(5 * `MINN_NFFT);
        predict_starts();
        stream_stimulus(1'b0, in_cnt, out_cnt);
        require(got_starts.size() == 0, "frame_start was raised on silent input");
        match_tags();
        print_test_line("silence", in_cnt, out_cnt, errs0);
    endtask

    task automatic single_preamble();
        int in_cnt;
        int out_cnt;
        int errs0;
        errs0 = error_count;
        stim.delete();
        pad_zeros(2 * `MINN_NFFT);
        insert_preamble(single_start);
        pad_zeros(4 * `MINN_NFFT);
        predict_starts();
        stream_stimulus(1'b0, in_cnt, out_cnt);
        match_tags();
        compare_value("main frame_start tags", tag_count(main_tag(single_start)), 1);
        print_test_line("single", in_cnt, out_cnt, errs0);
    endtask

    // Same stimulus as the single preamble, random output stalls
    task automatic stalled_output();
        int in_cnt;
        int out_cnt;
        int errs0;
        errs0 = error_count;
        predict_starts();
        stream_stimulus(1'b1, in_cnt, out_cnt);
        match_tags();
        compare_value("main frame_start tags", tag_count(main_tag(single_start)), 1);
        print_test_line("backpressure", in_cnt, out_cnt, errs0);
    endtask

    task automatic two_preambles();
        int in_cnt;
        int out_cnt;
        int errs0;
        int first;
        int second;
        errs0 = error_count;
        stim.delete();
        pad_zeros(2 * `MINN_NFFT);
        insert_preamble(first);
        pad_zeros(3 * `MINN_NFFT);
        insert_preamble(second);
        pad_zeros(4 * `MINN_NFFT);
        predict_starts();
        stream_stimulus(1'b0, in_cnt, out_cnt);
        match_tags();
        compare_value("first main frame_start tags", tag_count(main_tag(first)), 1);
        compare_value("second main frame_start tags", tag_count(main_tag(second)), 1);
        print_test_line("two", in_cnt, out_cnt, errs0);
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_sample   = '0;
        out_ready   = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        void'($urandom(32'hb82e));

        delay_passthrough();
        if (!timed_out) begin
            silent_input();
        end
        if (!timed_out) begin
            single_preamble();
        end
        if (!timed_out) begin
            stalled_output();
        end
        if (!timed_out) begin
            two_preambles();
        end

        $display("tests %0d checks %0d errors %0d", test_count, check_count, error_count);
        if (!timed_out && (error_count == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/minn_preamble_detector.sv
// ------------------------------------------------
// Two-antenna Minn preamble detector. Samples leave unchanged after
// NFFT accepted inputs, frame_start marks the estimated frame start
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module minn_preamble_detector (
    input  logic                   clk,
    input  logic                   rst,
    input  minn_pkg::dual_sample_t in_sample,
    input  logic                   in_valid,
    output logic                   in_ready,
    output minn_pkg::dual_sample_t out_sample,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   frame_start
);
    import minn_pkg::*;

    logic          sample_accept;
    logic          metric_valid;
    buf_addr_t     wr_idx;
    antenna_taps_t taps0;
    antenna_taps_t taps1;
    logic          taps0_valid;
    logic          taps1_valid;
    corr_total_t   corr_pos;
    logic          above;
    logic          det_pulse;
    buf_addr_t     det_idx;

    // Metric of sample n is judged when sample n+1 is accepted
    assign metric_valid = sample_accept && taps0_valid && taps1_valid;

    minn_delay_line u_delay_line (
        .clk           (clk),
        .rst           (rst),
        .in_sample     (in_sample),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_sample    (out_sample),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .frame_start   (frame_start),
        .wr_idx        (wr_idx),
        .sample_accept (sample_accept),
        .det_pulse     (det_pulse),
        .det_idx       (det_idx)
    );

    minn_antenna_path #(.IN_W(`MINN_IN_W)) u_antenna0 (
        .clk           (clk),
        .rst           (rst),
        .sample_accept (sample_accept),
        .sample        (in_sample.ch0),
        .taps          (taps0),
        .taps_valid    (taps0_valid)
    );

    minn_antenna_path #(.IN_W(`MINN_IN_W)) u_antenna1 (
        .clk           (clk),
        .rst           (rst),
        .sample_accept (sample_accept),
        .sample        (in_sample.ch1),
        .taps          (taps1),
        .taps_valid    (taps1_valid)
    );

    minn_metric u_metric (
        .taps0    (taps0),
        .taps1    (taps1),
        .corr_pos (corr_pos),
        .above    (above)
    );

    minn_peak_gate u_peak_gate (
        .clk          (clk),
        .rst          (rst),
        .metric_valid (metric_valid),
        .corr_pos     (corr_pos),
        .above        (above),
        .wr_idx       (wr_idx),
        .det_pulse    (det_pulse),
        .det_idx      (det_idx)
    );

endmodule

`default_nettype wire

//--- logic/minn_delay_line.sv
// ------------------------------------------------
// Output lags input by NFFT accepted samples. A full detection queue
// drops new detections
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module minn_delay_line (
    input  logic                   clk,
    input  logic                   rst,
    input  minn_pkg::dual_sample_t in_sample,
    input  logic                   in_valid,
    output logic                   in_ready,
    output minn_pkg::dual_sample_t out_sample,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   frame_start,
    output minn_pkg::buf_addr_t    wr_idx,
    output logic                   sample_accept,
    input  logic                   det_pulse,
    input  minn_pkg::buf_addr_t    det_idx
);
    import minn_pkg::*;

    localparam int ADDR_W = $bits(buf_addr_t);
    localparam int QD     = `MINN_DETQ_DEPTH;
    localparam int QP_W   = $clog2(QD);

    dual_sample_t    mem [`MINN_DEPTH];
    buf_addr_t       wr_ptr;
    buf_addr_t       rd_ptr;
    buf_addr_t       rd_inc;
    buf_addr_t       rd_next;
    logic [ADDR_W:0] fill_cnt;
    logic [ADDR_W:0] fill_next;
    det_timer_t      fill_gap;
    logic            load;
    logic            start_pending;

    det_timer_t      q_mem [QD];
    logic [QP_W-1:0] q_wr;
    logic [QP_W-1:0] q_rd;
    logic [QP_W:0]   q_cnt;
    det_timer_t      q_front;
    logic            push;
    logic            pop;

    // Loads needed to move from origin to target around the ring
    function automatic det_timer_t ring_dist(input buf_addr_t target, input buf_addr_t origin);
        if (target >= origin) begin
            return det_timer_t'(target) - det_timer_t'(origin);
        end
        return det_timer_t'(target) + det_timer_t'(`MINN_DEPTH) - det_timer_t'(origin);
    endfunction

    // Back-pressure comes only from the output register
    assign in_ready      = !out_valid || out_ready;
    assign sample_accept = in_valid && in_ready;
    assign wr_idx        = wr_ptr;
    assign load          = sample_accept && (fill_cnt >= (ADDR_W+1)'(`MINN_NFFT));
    assign frame_start   = out_valid && out_ready && start_pending;

    assign rd_inc    = (rd_ptr == buf_addr_t'(`MINN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign rd_next   = load ? rd_inc : rd_ptr;
    assign fill_next = (sample_accept && (fill_cnt < (ADDR_W+1)'(`MINN_DEPTH)))
        ? fill_cnt + 1'b1 : fill_cnt;
    assign fill_gap  = (fill_next >= (ADDR_W+1)'(`MINN_NFFT))
        ? '0 : det_timer_t'((ADDR_W+1)'(`MINN_NFFT) - fill_next);

    // ------------------------------------------------
    // Detection queue
    // ------------------------------------------------
    assign q_front = q_mem[q_rd];
    assign pop     = load && (q_cnt != '0) && (q_front == '0);
    assign push    = det_pulse && (q_cnt < (QP_W+1)'(QD));

    always_ff @(posedge clk) begin
        // Every waiting entry counts the loads still to come
        if (load) begin
            for (int k = 0; k < QD; k++) begin
                if (q_mem[k] != '0) begin
                    q_mem[k] <= q_mem[k] - 1'b1;
                end
            end
        end
        if (push) begin
            q_mem[q_wr] <= ring_dist(det_idx, rd_next) + fill_gap;
        end
        if (sample_accept) begin
            mem[wr_ptr] <= in_sample;
        end
        if (load) begin
            out_sample <= mem[rd_ptr];
        end
    end

    // ------------------------------------------------
    // Pointers, fill count and output valid
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill_cnt      <= '0;
            out_valid     <= 1'b0;
            start_pending <= 1'b0;
            q_wr          <= '0;
            q_rd          <= '0;
            q_cnt         <= '0;
        end else begin
            fill_cnt <= fill_next;
            rd_ptr   <= rd_next;
            if (sample_accept) begin
                wr_ptr <= (wr_ptr == buf_addr_t'(`MINN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (load) begin
                out_valid     <= 1'b1;
                start_pending <= pop;
            end else if (out_valid && out_ready) begin
                out_valid     <= 1'b0;
                start_pending <= 1'b0;
            end
            if (push) begin
                q_wr <= (q_wr == QP_W'(QD - 1)) ? '0 : q_wr + 1'b1;
            end
            if (pop) begin
                q_rd <= (q_rd == QP_W'(QD - 1)) ? '0 : q_rd + 1'b1;
            end
            q_cnt <= q_cnt + (QP_W+1)'(push) - (QP_W+1)'(pop);
        end
    end

    // A detection from the peak gate must find room in the queue
    assert property (@(posedge clk) disable iff (rst) det_pulse |-> (q_cnt < (QP_W+1)'(QD)))
        else $error("detection queue full, detection dropped");

endmodule

`default_nettype wire

//--- logic/minn_peak_gate.sv
// ------------------------------------------------
// Inputs are only sampled while metric_valid is high. det_idx holds
// the peak index shifted by the timing offset, modulo the buffer depth
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module minn_peak_gate (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  metric_valid,
    input  minn_pkg::corr_total_t corr_pos,
    input  logic                  above,
    input  minn_pkg::buf_addr_t   wr_idx,
    output logic                  det_pulse,
    output minn_pkg::buf_addr_t   det_idx
);
    import minn_pkg::*;

    localparam int ADDR_W   = $bits(buf_addr_t);
    localparam int OFF_NORM = ((`MINN_TIMING_OFFSET % `MINN_DEPTH) + `MINN_DEPTH) % `MINN_DEPTH;
    localparam int CNT_W    = $clog2(`MINN_HYST + 1);

    gate_state_t       state;
    corr_total_t       peak_val;
    buf_addr_t         peak_idx;
    buf_addr_t         offset_idx;
    logic [CNT_W-1:0]  low_cnt;
    logic [ADDR_W:0]   offset_sum;
    logic              take_peak;
    logic              close;

    // An equal metric also moves the peak, so the latest one wins
    assign take_peak = metric_valid
        && (((state == GATE_IDLE) && above) || ((state == GATE_OPEN) && (corr_pos >= peak_val)));
    assign close = metric_valid && (state == GATE_OPEN) && !above
        && (low_cnt == CNT_W'(`MINN_HYST - 1));

    assign offset_sum = {1'b0, peak_idx} + (ADDR_W+1)'(OFF_NORM);
    assign offset_idx = (offset_sum >= (ADDR_W+1)'(`MINN_DEPTH))
        ? buf_addr_t'(offset_sum - (ADDR_W+1)'(`MINN_DEPTH))
        : buf_addr_t'(offset_sum);

    // ------------------------------------------------
    // Gate FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= GATE_IDLE;
            low_cnt   <= '0;
            det_pulse <= 1'b0;
        end else begin
            det_pulse <= close;
            if (close) begin
                state   <= GATE_IDLE;
                low_cnt <= '0;
            end else if (metric_valid) begin
                if (state == GATE_IDLE) begin
                    low_cnt <= '0;
                    if (above) begin
                        state <= GATE_OPEN;
                    end
                end else if (above) begin
                    low_cnt <= '0;
                end else begin
                    low_cnt <= low_cnt + 1'b1;
                end
            end
        end
    end

    // Peak payload
    always_ff @(posedge clk) begin
        if (take_peak) begin
            peak_val <= corr_pos;
            peak_idx <= wr_idx;
        end
        if (close) begin
            det_idx <= offset_idx;
        end
    end

    // A detection is a single pulse, the gate needs a new open first
    assert property (@(posedge clk) disable iff (rst) det_pulse |=> !det_pulse)
        else $error("det_pulse lasted two cycles");

endmodule

`default_nettype wire

//--- logic/minn_metric.sv
// ------------------------------------------------
// Combinational metric, no pipeline stage
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module minn_metric (
    input  minn_pkg::antenna_taps_t taps0,
    input  minn_pkg::antenna_taps_t taps1,
    output minn_pkg::corr_total_t   corr_pos,
    output logic                    above
);
    import minn_pkg::*;

    localparam int CORR_SC_W   = $bits(corr_total_t) + `MINN_THRESH_FRAC;
    localparam int ENERGY_SC_W = $bits(energy_total_t) + $clog2(`MINN_THRESH + 1);
    localparam int CMP_W       = (CORR_SC_W > ENERGY_SC_W) ? CORR_SC_W : ENERGY_SC_W;

    corr_total_t      corr_total;
    energy_total_t    energy_total;
    logic [CMP_W-1:0] corr_scaled;
    logic [CMP_W-1:0] energy_scaled;

    // Four correlation windows, sign extended
    assign corr_total = corr_total_t'(taps0.corr_recent)
        + corr_total_t'(taps0.corr_previous)
        + corr_total_t'(taps1.corr_recent)
        + corr_total_t'(taps1.corr_previous);

    // Six energy windows
    assign energy_total = energy_total_t'(taps0.energy_recent)
        + energy_total_t'(taps0.energy_previous)
        + energy_total_t'(taps0.energy_previous2)
        + energy_total_t'(taps1.energy_recent)
        + energy_total_t'(taps1.energy_previous)
        + energy_total_t'(taps1.energy_previous2);

    // Negative correlation cannot start a frame
    assign corr_pos = corr_total[$bits(corr_total_t)-1] ? '0 : corr_total;

    // corr / energy > THRESH / 2^FRAC, without a divider
    assign corr_scaled   = CMP_W'($unsigned(corr_pos)) << `MINN_THRESH_FRAC;
    assign energy_scaled = CMP_W'(energy_total) * CMP_W'(`MINN_THRESH);
    assign above         = corr_scaled > energy_scaled;

endmodule

`default_nettype wire

//--- logic/minn_antenna_path.sv
// ------------------------------------------------
// Taps are registered one cycle after the accept. Windows read zero
// until filled, taps_valid rises after 4 quarters of samples
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "minn_consts.svh"

module minn_antenna_path #(
    parameter int IN_W = `MINN_IN_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_accept,
    input  minn_pkg::iq_sample_t    sample,
    output minn_pkg::antenna_taps_t taps,
    output logic                    taps_valid
);
    import minn_pkg::*;

    localparam int Q      = `MINN_QUARTER;
    localparam int PROD_W = 2 * IN_W + 1;

    logic signed [IN_W-1:0]   cur_i;
    logic signed [IN_W-1:0]   cur_q;
    logic signed [IN_W-1:0]   hist_i [Q];
    logic signed [IN_W-1:0]   hist_q [Q];
    logic signed [PROD_W-1:0] lag_line [3*Q];
    logic signed [PROD_W-1:0] pwr_line [3*Q];
    logic signed [PROD_W-1:0] lag_new;
    logic signed [PROD_W-1:0] pwr_new;
    logic [$clog2(4*Q)-1:0]   fill_cnt;

    assign cur_i = IN_W'(sample.i);
    assign cur_q = IN_W'(sample.q);

    // Real part of x(n) * conj(x(n-Q)), and |x(n)|^2
    assign lag_new = cur_i * hist_i[Q-1] + cur_q * hist_q[Q-1];
    assign pwr_new = cur_i * cur_i + cur_q * cur_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < Q; k++) begin
                hist_i[k] <= '0;
                hist_q[k] <= '0;
            end
            for (int k = 0; k < 3*Q; k++) begin
                lag_line[k] <= '0;
                pwr_line[k] <= '0;
            end
            taps       <= '0;
            fill_cnt   <= '0;
            taps_valid <= 1'b0;
        end else if (sample_accept) begin
            hist_i[0]   <= cur_i;
            hist_q[0]   <= cur_q;
            lag_line[0] <= lag_new;
            pwr_line[0] <= pwr_new;
            for (int k = 1; k < Q; k++) begin
                hist_i[k] <= hist_i[k-1];
                hist_q[k] <= hist_q[k-1];
            end
            for (int k = 1; k < 3*Q; k++) begin
                lag_line[k] <= lag_line[k-1];
                pwr_line[k] <= pwr_line[k-1];
            end

            // Each window adds its newest term and drops the one a quarter older
            taps.corr_recent <= taps.corr_recent + corr_win_t'(lag_new)
                - corr_win_t'(lag_line[Q-1]);
            taps.corr_previous <= taps.corr_previous + corr_win_t'(lag_line[2*Q-1])
                - corr_win_t'(lag_line[3*Q-1]);
            taps.energy_recent <= taps.energy_recent + energy_win_t'(pwr_new)
                - energy_win_t'(pwr_line[Q-1]);
            taps.energy_previous <= taps.energy_previous + energy_win_t'(pwr_line[Q-1])
                - energy_win_t'(pwr_line[2*Q-1]);
            taps.energy_previous2 <= taps.energy_previous2 + energy_win_t'(pwr_line[2*Q-1])
                - energy_win_t'(pwr_line[3*Q-1]);

            if (!taps_valid) begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == ($bits(fill_cnt))'(4*Q-1)) begin
                    taps_valid <= 1'b1;
                end
            end
        end
    end

    // Running power sum must match the power delay line
    assert property (@(posedge clk) disable iff (rst)
        !taps.energy_recent[$bits(energy_win_t)-1])
        else $error("energy_recent went negative");

endmodule

`default_nettype wire

//--- logic/minn_pkg.sv
// ------------------------------------------------
// Shared types. Window widths allow full growth over one quarter
// ------------------------------------------------
`default_nettype none
`include "minn_consts.svh"

package minn_pkg;

    typedef logic signed [`MINN_IN_W-1:0] iq_comp_t;

    // Lag product and power take 2*W+1 bits, a quarter window adds the rest
    typedef logic signed [2*`MINN_IN_W+$clog2(`MINN_QUARTER+1):0] corr_win_t;
    typedef logic [2*`MINN_IN_W+$clog2(`MINN_QUARTER+1):0] energy_win_t;

    // Four correlation windows and six energy windows combined
    typedef logic signed [$bits(corr_win_t)+1:0] corr_total_t;
    typedef logic [$bits(energy_win_t)+2:0] energy_total_t;

    typedef logic [$clog2(`MINN_DEPTH)-1:0] buf_addr_t;
    typedef logic [$bits(buf_addr_t)+1:0] det_timer_t;

    // i sits in the low bits
    typedef struct packed {
        iq_comp_t q;
        iq_comp_t i;
    } iq_sample_t;

    typedef struct packed {
        iq_sample_t ch1;
        iq_sample_t ch0;
    } dual_sample_t;

    typedef struct packed {
        corr_win_t   corr_recent;
        corr_win_t   corr_previous;
        energy_win_t energy_recent;
        energy_win_t energy_previous;
        energy_win_t energy_previous2;
    } antenna_taps_t;

    typedef enum logic {
        GATE_IDLE,
        GATE_OPEN
    } gate_state_t;

endpackage

`default_nettype wire

//--- logic/minn_consts.svh
// ------------------------------------------------
// Build constants of the preamble detector. Keep DEPTH = NFFT + CP_LEN
// and QUARTER = NFFT / 4, NFFT must be a multiple of 4
// ------------------------------------------------
`ifndef MINN_CONSTS_SVH
`define MINN_CONSTS_SVH

// Width of one I or Q component
`define MINN_IN_W 12

// Preamble geometry
`define MINN_NFFT 32
`define MINN_QUARTER (`MINN_NFFT / 4)
`define MINN_CP_LEN 8

// Buffer holds the detection latency plus the cyclic prefix margin
`define MINN_DEPTH (`MINN_NFFT + `MINN_CP_LEN)
`define MINN_TIMING_OFFSET (-`MINN_CP_LEN)

// Threshold ratio is THRESH / 2^THRESH_FRAC
`define MINN_THRESH 4096
`define MINN_THRESH_FRAC 15

// Consecutive low metrics before the gate closes
`define MINN_HYST 2

// Outstanding detections waiting for their sample
`define MINN_DETQ_DEPTH 4

`endif
